// ==== rtl/core_cfg_pkg.sv ====
// Register-file geometry for the slice; NREGS must stay a power of two and match reg_idx_t
package core_cfg_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Data width
  //////////////////////////////////////////////////////////////////////////

  // Default word width, overridden from the top level
  localparam int XLEN_DEF = 32;

  //////////////////////////////////////////////////////////////////////////
  // Register file geometry
  //////////////////////////////////////////////////////////////////////////

  // Architectural registers, x0 included
  localparam int NREGS = 32;

  // Index width derived from the register count
  localparam int REG_IDX_W = $clog2(NREGS);

  // Register index as carried on every port
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

endpackage : core_cfg_pkg

// ==== rtl/alu_op_pkg.sv ====
// ALU operation encoding; the 3-bit code is visible on the instruction port and must stay fixed
package alu_op_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Operation encoding
  //////////////////////////////////////////////////////////////////////////

  // All eight codes are used, so no illegal value exists
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////////////////////////////

  // Low bits of operand b that set the shift distance
  localparam int SHAMT_W = 5;

endpackage : alu_op_pkg

// ==== rtl/issue_stage.sv ====
// Four-phase instruction input; one instruction in flight, fields held by the source until ack
`timescale 1ns/1ps

module issue_stage #(
  parameter int XLEN = core_cfg_pkg::XLEN_DEF
)
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  // Instruction handshake from the source
  input  logic                   instr_req_i,
  input  alu_op_pkg::alu_op_e    instr_op_i,
  input  core_cfg_pkg::reg_idx_t instr_rd_i,
  input  core_cfg_pkg::reg_idx_t instr_rs1_i,
  input  core_cfg_pkg::reg_idx_t instr_rs2_i,
  input  logic [XLEN-1:0]        instr_imm_i,
  input  logic                   instr_use_imm_i,
  output logic                   instr_ack_o,

  // Result handshake closed in execute
  input  logic                   done_i,

  // Operand read request to the register file
  output logic                   rd_en_o,
  output core_cfg_pkg::reg_idx_t rs1_o,
  output core_cfg_pkg::reg_idx_t rs2_o,

  // Issued instruction towards execute
  output logic                   issue_valid_o,
  output alu_op_pkg::alu_op_e    op_o,
  output core_cfg_pkg::reg_idx_t rd_o,
  output logic [XLEN-1:0]        imm_o,
  output logic                   use_imm_o
);

  // Instruction in flight, set at acceptance
  logic busy;
  logic accept;

  ////////////////////////////////////////////////////////////////////////////
  // Acceptance
  ////////////////////////////////////////////////////////////////////////////

  // New request only once the previous ack has dropped and the slice is idle
  assign accept = instr_req_i && !busy && !instr_ack_o;

  // Read addresses go straight to the register file, registered there
  assign rd_en_o = accept;
  assign rs1_o   = instr_rs1_i;
  assign rs2_o   = instr_rs2_i;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake and busy state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      instr_ack_o   <= 1'b0;
      busy          <= 1'b0;
      issue_valid_o <= 1'b0;
    end
    else
    begin
      // Single-cycle issue pulse
      issue_valid_o <= accept;

      // Ack high at acceptance, low once req is seen low
      if (accept)
        instr_ack_o <= 1'b1;
      else if (!instr_req_i)
        instr_ack_o <= 1'b0;

      // Busy until the result handshake has closed
      if (accept)
        busy <= 1'b1;
      else if (done_i)
        busy <= 1'b0;
    end
  end

  // Instruction fields, captured once per acceptance
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      op_o      <= instr_op_i;
      rd_o      <= instr_rd_i;
      imm_o     <= instr_imm_i;
      use_imm_o <= instr_use_imm_i;
    end
  end

endmodule : issue_stage

// ==== rtl/reg_file.sv ====
// 32 x XLEN register file; register contents undefined after reset, x0 reads zero on all ports
`timescale 1ns/1ps

module reg_file #(
  parameter int XLEN = core_cfg_pkg::XLEN_DEF
)
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  // Operand read, addresses registered on rd_en_i
  input  logic                   rd_en_i,
  input  core_cfg_pkg::reg_idx_t rs1_i,
  input  core_cfg_pkg::reg_idx_t rs2_i,
  output logic [XLEN-1:0]        rdata1_o,
  output logic [XLEN-1:0]        rdata2_o,

  // Core writeback
  input  logic                   we_i,
  input  core_cfg_pkg::reg_idx_t waddr_i,
  input  logic [XLEN-1:0]        wdata_i,

  // Debug access
  input  logic                   dbg_we_i,
  input  core_cfg_pkg::reg_idx_t dbg_addr_i,
  input  logic [XLEN-1:0]        dbg_wdata_i,
  output logic [XLEN-1:0]        dbg_rdata_o
);

  // Storage, x0 location written but never read out
  logic [XLEN-1:0] regs [core_cfg_pkg::NREGS];

  // Registered read addresses
  core_cfg_pkg::reg_idx_t rs1_q;
  core_cfg_pkg::reg_idx_t rs2_q;
  core_cfg_pkg::reg_idx_t dbg_addr_q;

  // x0 flags, registered along with the addresses
  logic rs1_zero_q;
  logic rs2_zero_q;
  logic dbg_zero_q;

  ////////////////////////////////////////////////////////////////////////////
  // Operand read port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rd_en_i)
    begin
      rs1_q <= rs1_i;
      rs2_q <= rs2_i;
    end
  end

  // Flags come up set so the outputs read zero out of reset
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rs1_zero_q <= 1'b1;
      rs2_zero_q <= 1'b1;
    end
    else if (rd_en_i)
    begin
      rs1_zero_q <= (rs1_i == '0);
      rs2_zero_q <= (rs2_i == '0);
    end
  end

  // Read through from the array, so a write at the same edge shows up
  assign rdata1_o = rs1_zero_q ? '0 : regs[rs1_q];
  assign rdata2_o = rs2_zero_q ? '0 : regs[rs2_q];

  ////////////////////////////////////////////////////////////////////////////
  // Debug read port
  ////////////////////////////////////////////////////////////////////////////

  // Address sampled every edge
  always_ff @(posedge clk_i)
  begin
    dbg_addr_q <= dbg_addr_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      dbg_zero_q <= 1'b1;
    else
      dbg_zero_q <= (dbg_addr_i == '0);
  end

  assign dbg_rdata_o = dbg_zero_q ? '0 : regs[dbg_addr_q];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  // Debug write wins, a coinciding core write is dropped
  always_ff @(posedge clk_i)
  begin
    if (dbg_we_i)
      regs[dbg_addr_i] <= dbg_wdata_i;
    else if (we_i)
      regs[waddr_i] <= wdata_i;
  end

endmodule : reg_file

// ==== rtl/exec_stage.sv ====
// ALU and four-phase result output; sink must drop res_ack_i before the next result is offered
`timescale 1ns/1ps

module exec_stage #(
  parameter int XLEN = core_cfg_pkg::XLEN_DEF
)
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  // Issued instruction
  input  logic                   issue_valid_i,
  input  alu_op_pkg::alu_op_e    op_i,
  input  core_cfg_pkg::reg_idx_t rd_i,
  input  logic [XLEN-1:0]        imm_i,
  input  logic                   use_imm_i,

  // Operands, valid while issue_valid_i is high
  input  logic [XLEN-1:0]        rdata1_i,
  input  logic [XLEN-1:0]        rdata2_i,

  // Writeback to the register file
  output logic                   wb_we_o,
  output core_cfg_pkg::reg_idx_t wb_addr_o,
  output logic [XLEN-1:0]        wb_data_o,

  // Result handshake to the sink
  output logic                   res_req_o,
  input  logic                   res_ack_i,
  output core_cfg_pkg::reg_idx_t res_rd_o,
  output logic [XLEN-1:0]        res_data_o,

  // Handshake closed, frees the issue stage
  output logic                   done_o
);

  // Second operand after immediate select
  logic [XLEN-1:0]                 opb;
  logic [alu_op_pkg::SHAMT_W-1:0]  shamt;
  logic [XLEN-1:0]                 alu_res;

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  assign opb   = use_imm_i ? imm_i : rdata2_i;

  // Only the low bits of b shift
  assign shamt = opb[alu_op_pkg::SHAMT_W-1:0];

  always_comb
  begin
    case (op_i)
      alu_op_pkg::ALU_ADD: alu_res = rdata1_i + opb;
      alu_op_pkg::ALU_SUB: alu_res = rdata1_i - opb;
      alu_op_pkg::ALU_AND: alu_res = rdata1_i & opb;
      alu_op_pkg::ALU_OR:  alu_res = rdata1_i | opb;
      alu_op_pkg::ALU_XOR: alu_res = rdata1_i ^ opb;
      alu_op_pkg::ALU_SLL: alu_res = rdata1_i << shamt;
      alu_op_pkg::ALU_SRL: alu_res = rdata1_i >> shamt;
      // Signed compare, result is 0 or 1
      alu_op_pkg::ALU_SLT:
        alu_res = {{(XLEN-1){1'b0}}, ($signed(rdata1_i) < $signed(opb))};
      default: alu_res = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Writeback
  ////////////////////////////////////////////////////////////////////////////

  // Write lands at the same edge that registers the result
  assign wb_we_o   = issue_valid_i;
  assign wb_addr_o = rd_i;
  assign wb_data_o = alu_res;

  ////////////////////////////////////////////////////////////////////////////
  // Result handshake
  ////////////////////////////////////////////////////////////////////////////

  // Result held stable for as long as req is high
  always_ff @(posedge clk_i)
  begin
    if (issue_valid_i)
    begin
      res_rd_o   <= rd_i;
      res_data_o <= alu_res;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      res_req_o <= 1'b0;
    else if (issue_valid_i)
      res_req_o <= 1'b1;
    else if (res_ack_i)
      res_req_o <= 1'b0;
  end

  // High for the one cycle where req is still up and ack is seen
  assign done_o = res_req_o && res_ack_i;

endmodule : exec_stage

// ==== rtl/int_core_top.sv ====
// Execute slice top; one instruction in flight, debug port to be used only while idle
`timescale 1ns/1ps

module int_core_top #(
  parameter int XLEN = core_cfg_pkg::XLEN_DEF
)
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  // Instruction input, four-phase
  input  logic                   instr_req_i,
  input  alu_op_pkg::alu_op_e    instr_op_i,
  input  core_cfg_pkg::reg_idx_t instr_rd_i,
  input  core_cfg_pkg::reg_idx_t instr_rs1_i,
  input  core_cfg_pkg::reg_idx_t instr_rs2_i,
  input  logic [XLEN-1:0]        instr_imm_i,
  input  logic                   instr_use_imm_i,
  output logic                   instr_ack_o,

  // Result output, four-phase
  output logic                   res_req_o,
  input  logic                   res_ack_i,
  output core_cfg_pkg::reg_idx_t res_rd_o,
  output logic [XLEN-1:0]        res_data_o,

  // Debug access to the register file
  input  logic                   dbg_we_i,
  input  core_cfg_pkg::reg_idx_t dbg_addr_i,
  input  logic [XLEN-1:0]        dbg_wdata_i,
  output logic [XLEN-1:0]        dbg_rdata_o
);

  // Issue to register file
  logic                   rd_en;
  core_cfg_pkg::reg_idx_t rs1;
  core_cfg_pkg::reg_idx_t rs2;

  // Issue to execute
  logic                   issue_valid;
  alu_op_pkg::alu_op_e    op;
  core_cfg_pkg::reg_idx_t rd;
  logic [XLEN-1:0]        imm;
  logic                   use_imm;
  logic                   done;

  // Operands and writeback
  logic [XLEN-1:0]        rdata1;
  logic [XLEN-1:0]        rdata2;
  logic                   wb_we;
  core_cfg_pkg::reg_idx_t wb_addr;
  logic [XLEN-1:0]        wb_data;

  issue_stage #(
    .XLEN (XLEN)
  ) u_issue_stage (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .instr_req_i     (instr_req_i),
    .instr_op_i      (instr_op_i),
    .instr_rd_i      (instr_rd_i),
    .instr_rs1_i     (instr_rs1_i),
    .instr_rs2_i     (instr_rs2_i),
    .instr_imm_i     (instr_imm_i),
    .instr_use_imm_i (instr_use_imm_i),
    .instr_ack_o     (instr_ack_o),
    .done_i          (done),
    .rd_en_o         (rd_en),
    .rs1_o           (rs1),
    .rs2_o           (rs2),
    .issue_valid_o   (issue_valid),
    .op_o            (op),
    .rd_o            (rd),
    .imm_o           (imm),
    .use_imm_o       (use_imm)
  );

  reg_file #(
    .XLEN (XLEN)
  ) u_reg_file (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rd_en_i     (rd_en),
    .rs1_i       (rs1),
    .rs2_i       (rs2),
    .rdata1_o    (rdata1),
    .rdata2_o    (rdata2),
    .we_i        (wb_we),
    .waddr_i     (wb_addr),
    .wdata_i     (wb_data),
    .dbg_we_i    (dbg_we_i),
    .dbg_addr_i  (dbg_addr_i),
    .dbg_wdata_i (dbg_wdata_i),
    .dbg_rdata_o (dbg_rdata_o)
  );

  exec_stage #(
    .XLEN (XLEN)
  ) u_exec_stage (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .issue_valid_i (issue_valid),
    .op_i          (op),
    .rd_i          (rd),
    .imm_i         (imm),
    .use_imm_i     (use_imm),
    .rdata1_i      (rdata1),
    .rdata2_i      (rdata2),
    .wb_we_o       (wb_we),
    .wb_addr_o     (wb_addr),
    .wb_data_o     (wb_data),
    .res_req_o     (res_req_o),
    .res_ack_i     (res_ack_i),
    .res_rd_o      (res_rd_o),
    .res_data_o    (res_data_o),
    .done_o        (done)
  );

endmodule : int_core_top

// ==== sim/tb_int_core_props.sv ====
// Handshake and reset checks bound into int_core_top; fail_count is read by the testbench
`timescale 1ns/1ps

module tb_int_core_props #(
  parameter int XLEN = core_cfg_pkg::XLEN_DEF
)
(
  input logic                   clk_i,
  input logic                   reset_i,
  input logic                   instr_req_i,
  input logic                   instr_ack_o,
  input logic                   res_req_o,
  input logic                   res_ack_i,
  input core_cfg_pkg::reg_idx_t res_rd_o,
  input logic [XLEN-1:0]        res_data_o
);

  // Failed assertions so far
  int fail_count = 0;

  //////////////////////////////////////////////////////////////////////////
  // Instruction handshake
  //////////////////////////////////////////////////////////////////////////

  // Ack stays down while req is down
  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    !instr_req_i && !instr_ack_o |=> !instr_ack_o)
  else
  begin
    fail_count++;
    $error("instruction ack rose with no request");
  end

  // Acceptance to result request is one cycle
  a_res_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(instr_ack_o) |=> $rose(res_req_o))
  else
  begin
    fail_count++;
    $error("result request not one cycle after acceptance");
  end

  //////////////////////////////////////////////////////////////////////////
  // Result handshake and reset
  //////////////////////////////////////////////////////////////////////////

  // Held with stable payload until the sink acks
  a_res_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    res_req_o && !res_ack_i |=> res_req_o && $stable(res_data_o) && $stable(res_rd_o))
  else
  begin
    fail_count++;
    $error("result request or payload changed before ack");
  end

  a_reset_idle: assert property (@(posedge clk_i)
    reset_i |=> !instr_ack_o && !res_req_o)
  else
  begin
    fail_count++;
    $error("handshake outputs not low after reset");
  end

endmodule : tb_int_core_props

// ==== sim/tb_int_core.sv ====
// Registers are seeded through the debug port before any instruction; debug used only while idle
`timescale 1ns/1ps

module tb_int_core;

  localparam int XLEN      = 32;
  localparam int RESET_CYC = 8;
  localparam int NREGS     = core_cfg_pkg::NREGS;
  localparam int N_RR      = 300;
  localparam int N_IMM     = 150;
  localparam int N_DEP     = 50;
  localparam int N_BP      = 100;
  localparam int N_INSTR   = N_RR + N_IMM + N_DEP + N_BP;
  // Seeding writes, first readback, final readback
  localparam int N_DBG     = 3 * NREGS;
  localparam int LIMIT_NS  = 100 * (N_INSTR * 40 + N_DBG * 4 + RESET_CYC);

  logic                   clk_i = 1'b0;
  logic                   reset_i;
  logic                   instr_req_i;
  alu_op_pkg::alu_op_e    instr_op_i;
  core_cfg_pkg::reg_idx_t instr_rd_i;
  core_cfg_pkg::reg_idx_t instr_rs1_i;
  core_cfg_pkg::reg_idx_t instr_rs2_i;
  logic [XLEN-1:0]        instr_imm_i;
  logic                   instr_use_imm_i;
  logic                   instr_ack_o;
  logic                   res_req_o;
  logic                   res_ack_i;
  core_cfg_pkg::reg_idx_t res_rd_o;
  logic [XLEN-1:0]        res_data_o;
  logic                   dbg_we_i;
  core_cfg_pkg::reg_idx_t dbg_addr_i;
  logic [XLEN-1:0]        dbg_wdata_i;
  logic [XLEN-1:0]        dbg_rdata_o;

  // Register model with x0 kept at zero
  logic [XLEN-1:0]        model_regs [NREGS];
  // Expected results and ack delays in issue order
  logic [XLEN-1:0]        exp_data_q [$];
  core_cfg_pkg::reg_idx_t exp_rd_q [$];
  int                     delay_q [$];
  int                     accepts = 0;
  int                     completions = 0;
  bit                     ack_seen = 1'b0;
  bit                     req_seen = 1'b0;
  core_cfg_pkg::reg_idx_t prev_rd = '0;
  string                  phase = "reset";

  int_core_top #(.XLEN(XLEN)) u_int_core_top (.*);

  bind int_core_top tb_int_core_props #(.XLEN(XLEN)) u_props (.*);

  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Checks and model
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
    if (actual !== expected)
      fail_stop($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
  endtask

  task automatic check_idx(input string name, input core_cfg_pkg::reg_idx_t expected,
                           input core_cfg_pkg::reg_idx_t actual);
    if (actual !== expected)
      fail_stop($sformatf("FAIL %s expected %0d actual %0d", name, expected, actual));
  endtask

  function automatic logic [XLEN-1:0] alu_model(input alu_op_pkg::alu_op_e op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [alu_op_pkg::SHAMT_W-1:0] sh;
    logic                           lt;
    sh = b[alu_op_pkg::SHAMT_W-1:0];
    // Negative operand is less when the signs differ
    // Equal signs order the same as unsigned
    lt = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b);
    case (op)
      alu_op_pkg::ALU_ADD: return a + b;
      alu_op_pkg::ALU_SUB: return a - b;
      alu_op_pkg::ALU_AND: return a & b;
      alu_op_pkg::ALU_OR:  return a | b;
      alu_op_pkg::ALU_XOR: return a ^ b;
      alu_op_pkg::ALU_SLL: return a << sh;
      alu_op_pkg::ALU_SRL: return a >> sh;
      alu_op_pkg::ALU_SLT: return {{(XLEN-1){1'b0}}, lt};
      default:             return '0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic dbg_write(input core_cfg_pkg::reg_idx_t addr, input logic [XLEN-1:0] data);
    @(posedge clk_i);
    dbg_we_i    <= 1'b1;
    dbg_addr_i  <= addr;
    dbg_wdata_i <= data;
    @(posedge clk_i);
    dbg_we_i    <= 1'b0;
  endtask

  // Address taken at the next edge, data one cycle later
  task automatic dbg_check(input core_cfg_pkg::reg_idx_t addr);
    @(posedge clk_i);
    dbg_addr_i <= addr;
    @(posedge clk_i);
    @(negedge clk_i);
    check_data($sformatf("%s x%0d", phase, addr), model_regs[addr], dbg_rdata_o);
  endtask

  task automatic send_instr(input bit use_imm, input bit dep, input int max_delay,
                            input bit early);
    alu_op_pkg::alu_op_e    op;
    core_cfg_pkg::reg_idx_t rd;
    core_cfg_pkg::reg_idx_t rs1;
    core_cfg_pkg::reg_idx_t rs2;
    logic [XLEN-1:0]        imm;
    logic [XLEN-1:0]        result;
    op  = alu_op_pkg::alu_op_e'($urandom_range(0, 7));
    rd  = core_cfg_pkg::reg_idx_t'($urandom_range(0, NREGS - 1));
    rs1 = core_cfg_pkg::reg_idx_t'($urandom_range(0, NREGS - 1));
    rs2 = core_cfg_pkg::reg_idx_t'($urandom_range(0, NREGS - 1));
    imm = $urandom();
    // Read back the last destination on a side that is actually used
    if (dep)
    begin
      if (use_imm || $urandom_range(0, 1) == 1)
        rs1 = prev_rd;
      else
        rs2 = prev_rd;
    end
    result = alu_model(op, model_regs[rs1], use_imm ? imm : model_regs[rs2]);
    if (rd != '0)
      model_regs[rd] = result;
    prev_rd = rd;
    exp_data_q.push_back(result);
    exp_rd_q.push_back(rd);
    delay_q.push_back($urandom_range(0, max_delay));
    // Without early req, wait for the previous result to close
    while (!early && completions != accepts)
      @(negedge clk_i);
    @(posedge clk_i);
    instr_op_i      <= op;
    instr_rd_i      <= rd;
    instr_rs1_i     <= rs1;
    instr_rs2_i     <= rs2;
    instr_imm_i     <= imm;
    instr_use_imm_i <= use_imm;
    instr_req_i     <= 1'b1;
    @(negedge clk_i);
    while (!instr_ack_o)
      @(negedge clk_i);
    @(posedge clk_i);
    instr_req_i <= 1'b0;
    @(negedge clk_i);
    while (instr_ack_o)
      @(negedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Result sink and handshake monitor
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : result_sink
    logic [XLEN-1:0]        exp_data;
    core_cfg_pkg::reg_idx_t exp_rd;
    int                     delay;
    forever
    begin
      @(negedge clk_i);
      if (res_req_o)
      begin
        if (exp_data_q.size() == 0)
          fail_stop("Result offered with no instruction outstanding");
        exp_data = exp_data_q.pop_front();
        exp_rd   = exp_rd_q.pop_front();
        delay    = delay_q.pop_front();
        check_idx({phase, " rd"}, exp_rd, res_rd_o);
        check_data({phase, " data"}, exp_data, res_data_o);
        // Payload must not move under back-pressure
        repeat (delay)
        begin
          @(negedge clk_i);
          if (!res_req_o)
            fail_stop("Result request dropped before the ack was given");
          check_data({phase, " held data"}, exp_data, res_data_o);
        end
        @(posedge clk_i);
        res_ack_i <= 1'b1;
        @(negedge clk_i);
        while (res_req_o)
          @(negedge clk_i);
        @(posedge clk_i);
        res_ack_i <= 1'b0;
      end
    end
  end

  // Each acceptance needs the previous result handshake closed
  always @(negedge clk_i)
  begin
    if (!reset_i)
    begin
      if (instr_ack_o && !ack_seen)
      begin
        if (accepts != completions)
          fail_stop("Instruction accepted before the previous result handshake closed");
        accepts++;
      end
      if (!res_req_o && req_seen)
        completions++;
    end
    ack_seen = instr_ack_o;
    req_seen = res_req_o;
  end

  // Any bound assertion failure ends the run
  always @(u_int_core_top.u_props.fail_count)
  begin
    if (u_int_core_top.u_props.fail_count != 0)
      fail_stop("A bound handshake assertion failed");
  end

  initial
  begin : watchdog
    #(LIMIT_NS);
    fail_stop("Timeout, the run took longer than its tests allow");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : main
    logic [XLEN-1:0] wdata;
    void'($urandom(32'hf046));
    reset_i         <= 1'b1;
    instr_req_i     <= 1'b0;
    instr_op_i      <= alu_op_pkg::ALU_ADD;
    instr_rd_i      <= '0;
    instr_rs1_i     <= '0;
    instr_rs2_i     <= '0;
    instr_imm_i     <= '0;
    instr_use_imm_i <= 1'b0;
    res_ack_i       <= 1'b0;
    dbg_we_i        <= 1'b0;
    dbg_addr_i      <= '0;
    dbg_wdata_i     <= '0;
    repeat (RESET_CYC)
      @(posedge clk_i);
    reset_i <= 1'b0;

    // Seed every register while x0 keeps reading zero
    phase = "debug";
    model_regs[0] = '0;
    for (int i = 0; i < NREGS; i++)
    begin
      wdata = $urandom();
      dbg_write(core_cfg_pkg::reg_idx_t'(i), wdata);
      if (i != 0)
        model_regs[i] = wdata;
    end
    for (int i = 0; i < NREGS; i++)
      dbg_check(core_cfg_pkg::reg_idx_t'(i));

    phase = "reg-reg";
    repeat (N_RR)
      send_instr(1'b0, 1'b0, 0, 1'b0);
    phase = "immediate";
    repeat (N_IMM)
      send_instr(1'b1, 1'b0, 0, 1'b0);
    // Next request already waiting while the previous result closes
    phase = "dependency";
    repeat (N_DEP)
      send_instr(1'($urandom_range(0, 1)), 1'b1, 0, 1'b1);
    phase = "backpressure";
    repeat (N_BP)
      send_instr(1'($urandom_range(0, 1)), 1'b0, 10, 1'b1);

    // Drain the last result before touching the debug port
    while (exp_data_q.size() != 0 || completions != accepts)
      @(negedge clk_i);
    phase = "final";
    for (int i = 0; i < NREGS; i++)
      dbg_check(core_cfg_pkg::reg_idx_t'(i));

    if (u_int_core_top.u_props.fail_count == 0)
    begin
      $display("STATUS: PASS");
      $finish;
    end
    else
      fail_stop("A bound handshake assertion failed during the run");
  end

endmodule : tb_int_core

// ==== compile.f ====
rtl/core_cfg_pkg.sv
rtl/alu_op_pkg.sv
rtl/issue_stage.sv
rtl/reg_file.sv
rtl/exec_stage.sv
rtl/int_core_top.sv
sim/tb_int_core_props.sv
sim/tb_int_core.sv
